// ==== list.f ====
+incdir+verilog
verilog/systolic_pkg.sv
verilog/mac_cell.sv
verilog/mac_array.sv
verilog/act_skew.sv
verilog/result_deskew.sv
verilog/array_ctrl.sv
verilog/systolic_top.sv
tb/systolic_checker.sv
tb/tb_systolic.sv

// ==== tb/systolic_checker.sv ====
`default_nettype none

`include "systolic_defs.svh"

module systolic_checker (
    input logic clk_i,
    input logic rst_i,
    input logic stall_i,
    input logic load_weights_i,
    input logic compute_i,
    input logic result_valid_o,
    input logic weights_ready_o,
    input logic pipe_empty_o
);

    localparam int LATENCY = 2 * `ARRAY_DIM - 2;

    int unsigned err_cnt = 0;
    logic        compute_accept;

    assign compute_accept = compute_i && !stall_i && !load_weights_i && weights_ready_o;

    assert property (@(posedge clk_i) rst_i |-> !result_valid_o && !weights_ready_o)
        else begin
            err_cnt++;
            $error("result_valid_o or weights_ready_o is high during reset");
        end

    // a vector on display is still in flight.
    assert property (@(posedge clk_i) disable iff (rst_i) !(pipe_empty_o && result_valid_o))
        else begin
            err_cnt++;
            $error("pipe_empty_o and result_valid_o are high together");
        end

    assert property (@(posedge clk_i) disable iff (rst_i)
        compute_accept ##1 (!stall_i) [* LATENCY] |=> result_valid_o)
        else begin
            err_cnt++;
            $error("result_valid_o missing after an unstalled compute");
        end

    // with an empty pipeline nothing may show up one step early.
    assert property (@(posedge clk_i) disable iff (rst_i)
        compute_accept && pipe_empty_o ##1 (!stall_i) [* LATENCY-1] |=> !result_valid_o)
        else begin
            err_cnt++;
            $error("result_valid_o rose before the full latency");
        end

endmodule

bind systolic_top systolic_checker i_systolic_checker (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .stall_i         (stall_i),
    .load_weights_i  (load_weights_i),
    .compute_i       (compute_i),
    .result_valid_o  (result_valid_o),
    .weights_ready_o (weights_ready_o),
    .pipe_empty_o    (pipe_empty_o)
);

`default_nettype wire

// ==== tb/tb_systolic.sv ====
`default_nettype none

`include "systolic_defs.svh"

module tb_systolic import systolic_pkg::*; ();

    localparam int LATENCY     = 2 * `ARRAY_DIM - 2;
    localparam int STIM_CYCLES = 160; // rough count of driven cycles.
    localparam int DRAIN_MAX   = 50;

    logic        clk_i = 1'b0;
    logic        rst_i;
    logic        stall_i;
    logic        load_weights_i;
    logic        compute_i;
    weight_vec_t weight_row_i;
    act_vec_t    act_vec_i;
    psum_vec_t   result_vec_o;
    logic        result_valid_o;
    logic        weights_ready_o;
    logic        pipe_empty_o;

    logic [31:0] lcg_state = 32'h433b;
    weight_t     model_w [`ARRAY_DIM][`ARRAY_DIM] = '{default: '0};
    int          model_rows = 0; // rows of the current weight set.
    psum_vec_t   exp_q [$];
    int          due_q [$];      // step count at which each result is due.
    int          steps = 0;
    psum_vec_t   last_vec = '0;
    logic        last_valid = 1'b0;
    logic        last_stall = 1'b0;

    always #50 clk_i = ~clk_i;

    systolic_top i_systolic_top (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .stall_i         (stall_i),
        .load_weights_i  (load_weights_i),
        .compute_i       (compute_i),
        .weight_row_i    (weight_row_i),
        .act_vec_i       (act_vec_i),
        .result_vec_o    (result_vec_o),
        .result_valid_o  (result_valid_o),
        .weights_ready_o (weights_ready_o),
        .pipe_empty_o    (pipe_empty_o)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // y[i] = sum over j of w[i][j] * x[j], wrapping at 32 bits.
    function automatic psum_vec_t expected_product(act_vec_t x);
        psum_vec_t y;
        y = '0;
        for (int i = 0; i < `ARRAY_DIM; i++) begin
            for (int j = 0; j < `ARRAY_DIM; j++) begin
                y[i] = y[i] + psum_t'(model_w[i][j]) * psum_t'(x[j]);
            end
        end
        return y;
    endfunction

    task automatic report_mismatch(string name, logic [`PSUM_W-1:0] got,
                                   logic [`PSUM_W-1:0] exp);
        $display("Fail %s: got %h, expected %h", name, got, exp);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(string what);
        $display("Error: %s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic drive_cycle(input logic stall, input logic load, input logic comp);
        logic [31:0] r;
        weight_vec_t row;
        act_vec_t    x;
        for (int j = 0; j < `ARRAY_DIM; j++) begin
            r      = next_rand();
            row[j] = r[31:24];
            x[j]   = r[23:8];
        end
        @(posedge clk_i);
        stall_i        <= stall;
        load_weights_i <= load;
        compute_i      <= comp;
        weight_row_i   <= row; // data changes every cycle, requested or not.
        act_vec_i      <= x;
    endtask

    task automatic stream(int cycles, logic [3:0] stall_lvl);
        logic [31:0] r;
        for (int c = 0; c < cycles; c++) begin
            r = next_rand();
            drive_cycle(r[31:28] < stall_lvl, 1'b0, r[27:26] != 2'b00);
        end
    endtask

    task automatic wait_drained();
        drive_cycle(1'b0, 1'b0, 1'b0);
        for (int n = 0; n < DRAIN_MAX; n++) begin
            @(negedge clk_i);
            if (pipe_empty_o) begin
                return;
            end
        end
        abort_run("the pipeline did not drain");
    endtask

    // outputs and inputs are both stable at the falling edge.
    always @(negedge clk_i) begin : monitor
        logic busy;
        logic due_now;
        busy    = (exp_q.size() != 0);
        due_now = busy && (due_q[0] == steps);
        if (!rst_i) begin
            assert (i_systolic_top.i_systolic_checker.err_cnt == 0)
                else abort_run("a protocol assertion on the DUT failed");
            if (last_stall) begin // the edge just passed did not step.
                assert (result_valid_o == last_valid)
                    else report_mismatch("result_valid_o", result_valid_o, last_valid);
                for (int i = 0; i < `ARRAY_DIM; i++) begin
                    assert (result_vec_o[i] == last_vec[i])
                        else report_mismatch($sformatf("result_vec_o[%0d]", i),
                                             result_vec_o[i], last_vec[i]);
                end
            end
            if (result_valid_o && !busy) begin
                abort_run("a result arrived with no compute outstanding");
            end
            assert (weights_ready_o == (model_rows == `ARRAY_DIM))
                else report_mismatch("weights_ready_o", weights_ready_o,
                                     model_rows == `ARRAY_DIM);
            assert (pipe_empty_o == !busy)
                else report_mismatch("pipe_empty_o", pipe_empty_o, !busy);
            assert (result_valid_o == due_now)
                else report_mismatch("result_valid_o", result_valid_o, due_now);
            if (result_valid_o) begin
                for (int i = 0; i < `ARRAY_DIM; i++) begin
                    assert (result_vec_o[i] == exp_q[0][i])
                        else report_mismatch($sformatf("result_vec_o[%0d]", i),
                                             result_vec_o[i], exp_q[0][i]);
                end
                if (!stall_i) begin
                    void'(exp_q.pop_front());
                    void'(due_q.pop_front());
                end
            end
            if (load_weights_i && !stall_i && !busy) begin
                for (int i = `ARRAY_DIM - 1; i > 0; i--) begin
                    model_w[i] = model_w[i-1];
                end
                for (int j = 0; j < `ARRAY_DIM; j++) begin
                    model_w[0][j] = weight_row_i[j];
                end
                model_rows = (model_rows == `ARRAY_DIM) ? 1 : model_rows + 1;
            end
            if (compute_i && !stall_i && !load_weights_i && model_rows == `ARRAY_DIM) begin
                exp_q.push_back(expected_product(act_vec_i));
                due_q.push_back(steps + 1 + LATENCY);
            end
            if (!stall_i) begin
                steps++;
            end
        end
        last_vec   = result_vec_o;
        last_valid = result_valid_o;
        last_stall = stall_i;
    end

    initial begin
        #((STIM_CYCLES * 3 + 200) * 100);
        abort_run("timeout, the run did not finish in time");
    end

    initial begin
        rst_i          <= 1'b1;
        stall_i        = 1'b0;
        load_weights_i = 1'b0;
        compute_i      = 1'b0;
        weight_row_i   = '0;
        act_vec_i      = '0;
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        assert (!result_valid_o && !weights_ready_o && pipe_empty_o)
            else abort_run("outputs are not at their reset values");

        // the compute in the middle of the set must be dropped.
        drive_cycle(1'b0, 1'b1, 1'b0);
        drive_cycle(1'b0, 1'b1, 1'b0);
        drive_cycle(1'b0, 1'b0, 1'b1);
        drive_cycle(1'b0, 1'b1, 1'b1);
        drive_cycle(1'b0, 1'b1, 1'b0);
        wait_drained();

        repeat (3) begin
            drive_cycle(1'b0, 1'b0, 1'b1);
            wait_drained();
        end

        repeat (8) drive_cycle(1'b0, 1'b0, 1'b1);
        wait_drained();

        stream(40, 4'd6);
        wait_drained();

        // loads with vectors in flight leave the weights alone.
        drive_cycle(1'b0, 1'b0, 1'b1);
        drive_cycle(1'b0, 1'b1, 1'b0);
        drive_cycle(1'b0, 1'b1, 1'b1);
        repeat (4) drive_cycle(1'b0, 1'b0, 1'b1);
        wait_drained();

        drive_cycle(1'b0, 1'b1, 1'b1); // load wins over compute.
        repeat (3) drive_cycle(1'b0, 1'b1, 1'b0); // a fresh weight set.
        stream(20, 4'd4);
        wait_drained();

        if (exp_q.size() != 0) begin
            abort_run("results were still outstanding at the end of the run");
        end else if (i_systolic_top.i_systolic_checker.err_cnt != 0) begin
            abort_run("a protocol assertion on the DUT failed");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/act_skew.sv ====
`default_nettype none

`include "systolic_defs.svh"

module act_skew import systolic_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     step_i,
    input  logic     act_accept_i,
    input  act_vec_t act_vec_i,
    output act_vec_t act_top_o
);

    act_vec_t act_gated;

    // bubbles enter the array as zero vectors.
    assign act_gated = act_accept_i ? act_vec_i : '0;

    assign act_top_o[0] = act_gated[0]; // column 0 goes straight in.

    // column j waits j steps so that it meets the running sum of each row
    // at the right cell.
    for (genvar j = 1; j < `ARRAY_DIM; j++) begin : g_col
        act_t dly_q [j];

        always_ff @(posedge clk_i, posedge rst_i) begin
            if (rst_i) begin
                dly_q <= '{default: '0};
            end else if (step_i) begin
                dly_q[0] <= act_gated[j];
                for (int k = 1; k < j; k++) begin
                    dly_q[k] <= dly_q[k-1];
                end
            end
        end

        assign act_top_o[j] = dly_q[j-1];
    end

    // The last column carries the longest line, ARRAY_DIM - 1 registers.
    // Each accepted vector thus leaves the skew as a diagonal wavefront, one
    // column per step, and consecutive vectors follow one step apart.

endmodule

`default_nettype wire

// ==== verilog/array_ctrl.sv ====
`default_nettype none

`include "systolic_defs.svh"

module array_ctrl import systolic_pkg::*; (
    input  logic clk_i,
    input  logic rst_i,
    input  logic stall_i,
    input  logic load_weights_i,
    input  logic compute_i,
    output logic step_o,
    output logic weight_shift_o,
    output logic act_accept_o,
    output logic result_valid_o,
    output logic weights_ready_o,
    output logic pipe_empty_o
);

    // steps from the accept edge to the result at the output.
    localparam int LATENCY = 2 * `ARRAY_DIM - 2;
    localparam int CNT_W   = $clog2(`ARRAY_DIM + 1);

    wset_state_t      state_q;
    logic [CNT_W-1:0] row_cnt_q;   // rows loaded in the current weight set.
    logic [CNT_W-1:0] row_cnt_next;
    logic [LATENCY:0] valid_q;     // bit k is set k steps after an accept.
    logic             load_accept;
    logic             compute_accept;

    assign step_o = !stall_i;

    // a load needs an empty pipeline, a compute needs a full weight set.
    // Load has priority when both are requested.
    assign load_accept    = load_weights_i && !stall_i && pipe_empty_o;
    assign compute_accept = compute_i && !stall_i && !load_weights_i && weights_ready_o;

    assign weight_shift_o = load_accept;
    assign act_accept_o   = compute_accept;

    assign weights_ready_o = (state_q == READY);
    assign result_valid_o  = valid_q[LATENCY];
    assign pipe_empty_o    = ~|valid_q; // includes the result now on display.

    // a load in READY starts the next set from its first row.
    assign row_cnt_next = (state_q == READY) ? CNT_W'(1) : row_cnt_q + 1'b1;

    always_ff @(posedge clk_i, posedge rst_i) begin
        if (rst_i) begin
            state_q   <= EMPTY;
            row_cnt_q <= '0;
        end else if (load_accept) begin
            row_cnt_q <= row_cnt_next;
            if (row_cnt_next == CNT_W'(`ARRAY_DIM)) begin
                state_q <= READY;
            end else begin
                state_q <= LOADING;
            end
        end
    end

    // the valid bits travel alongside the data and freeze with it on stall.
    always_ff @(posedge clk_i, posedge rst_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (step_o) begin
            valid_q <= {valid_q[LATENCY-1:0], compute_accept};
        end
    end

    // Stage 0 takes the accept at the accept edge itself, so the bit reaches
    // stage LATENCY on the same edge as the deskewed vector.
    //
    // A row counter below ARRAY_DIM keeps the controller in LOADING, and the
    // weights it has shifted in so far are not yet usable for a compute.
    // Requests that are not accepted leave every register unchanged.

endmodule

`default_nettype wire

// ==== verilog/mac_array.sv ====
`default_nettype none

`include "systolic_defs.svh"

module mac_array import systolic_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        step_i,
    input  logic        weight_shift_i,
    input  weight_vec_t weight_row_i,
    input  act_vec_t    act_top_i,
    output psum_vec_t   row_sum_o
);

    // vertical links have one extra row for the top ports, horizontal links
    // one extra column for the zero sum at the left edge.
    weight_t weight_w [`ARRAY_DIM+1][`ARRAY_DIM];
    act_t    act_w    [`ARRAY_DIM+1][`ARRAY_DIM];
    psum_t   psum_w   [`ARRAY_DIM][`ARRAY_DIM+1];

    for (genvar j = 0; j < `ARRAY_DIM; j++) begin : g_top
        assign weight_w[0][j] = weight_row_i[j];
        assign act_w[0][j]    = act_top_i[j];
    end

    for (genvar i = 0; i < `ARRAY_DIM; i++) begin : g_edge
        assign psum_w[i][0] = '0; // no bias, rows start from zero.
        assign row_sum_o[i] = psum_w[i][`ARRAY_DIM];
    end

    // cell (i,j) holds w[i][j]. Activations run down column j and the sum of
    // row i runs to the right, one cell per step.
    for (genvar i = 0; i < `ARRAY_DIM; i++) begin : g_row
        for (genvar j = 0; j < `ARRAY_DIM; j++) begin : g_col
            mac_cell i_mac_cell (
                .clk_i          (clk_i),
                .rst_i          (rst_i),
                .step_i         (step_i),
                .weight_shift_i (weight_shift_i),
                .weight_i       (weight_w[i][j]),
                .act_i          (act_w[i][j]),
                .psum_i         (psum_w[i][j]),
                .weight_o       (weight_w[i+1][j]),
                .act_o          (act_w[i+1][j]),
                .psum_o         (psum_w[i][j+1])
            );
        end
    end

    // the bottom row of weight and activation links leaves the grid unread.
    // Weights pushed out of the last row are simply dropped when a new set
    // is loaded.

    // With the column skew in front, the sum of row i leaves the right edge
    // i + ARRAY_DIM - 1 steps after column 0 takes its activation.

endmodule

`default_nettype wire

// ==== verilog/mac_cell.sv ====
`default_nettype none

`include "systolic_defs.svh"

module mac_cell import systolic_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    step_i,
    input  logic    weight_shift_i,
    input  weight_t weight_i,
    input  act_t    act_i,
    input  psum_t   psum_i,
    output weight_t weight_o,
    output act_t    act_o,
    output psum_t   psum_o
);

    weight_t weight_q; // stationary weight of this cell.
    act_t    act_q;
    psum_t   psum_q;

    always_ff @(posedge clk_i, posedge rst_i) begin
        if (rst_i) begin
            weight_q <= '0;
            act_q    <= '0;
            psum_q   <= '0;
        end else if (step_i) begin
            act_q <= act_i;
            // the product is widened to the sum width before the add.
            psum_q <= psum_i + act_i * weight_q;
            if (weight_shift_i) begin
                weight_q <= weight_i; // the old weight moves on to the row below.
            end
        end
    end

    assign weight_o = weight_q;
    assign act_o    = act_q;
    assign psum_o   = psum_q;

    // a weight shift never coincides with a product that matters, since loads
    // are only accepted with the pipeline empty.

endmodule

`default_nettype wire

// ==== verilog/result_deskew.sv ====
`default_nettype none

`include "systolic_defs.svh"

module result_deskew import systolic_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      step_i,
    input  psum_vec_t row_sum_i,
    output psum_vec_t result_vec_o
);

    // row i finishes i steps after row 0, so the upper rows wait longer.
    for (genvar i = 0; i < `ARRAY_DIM; i++) begin : g_row
        if (i == `ARRAY_DIM - 1) begin : g_pass
            assign result_vec_o[i] = row_sum_i[i]; // the last row is already in step.
        end else begin : g_dly
            localparam int DEPTH = `ARRAY_DIM - 1 - i;

            psum_t dly_q [DEPTH];

            always_ff @(posedge clk_i, posedge rst_i) begin
                if (rst_i) begin
                    dly_q <= '{default: '0};
                end else if (step_i) begin
                    dly_q[0] <= row_sum_i[i];
                    for (int k = 1; k < DEPTH; k++) begin
                        dly_q[k] <= dly_q[k-1];
                    end
                end
            end

            assign result_vec_o[i] = dly_q[DEPTH-1];
        end
    end

    // all elements of one vector now appear together, 2*ARRAY_DIM - 2 steps
    // after the vector was accepted.

    // While stalled nothing here moves and the last row's cell holds its sum,
    // so the whole output vector holds as well.

endmodule

`default_nettype wire

// ==== verilog/systolic_defs.svh ====
`ifndef SYSTOLIC_DEFS_SVH
`define SYSTOLIC_DEFS_SVH

// rows and columns of the square array.
`define ARRAY_DIM 4

`define WEIGHT_W 8
`define ACT_W 16
`define PSUM_W 32 // sums wrap modulo 2**32.

`endif

// ==== verilog/systolic_pkg.sv ====
`default_nettype none

`include "systolic_defs.svh"

package systolic_pkg;

    typedef logic [`WEIGHT_W-1:0] weight_t;
    typedef logic [`ACT_W-1:0]    act_t;
    typedef logic [`PSUM_W-1:0]   psum_t;

    // element k of a vector belongs to column k (or to row k for sums).
    typedef weight_t [`ARRAY_DIM-1:0] weight_vec_t;
    typedef act_t    [`ARRAY_DIM-1:0] act_vec_t;
    typedef psum_t   [`ARRAY_DIM-1:0] psum_vec_t;

    typedef enum logic [1:0] {EMPTY, LOADING, READY} wset_state_t;

endpackage

`default_nettype wire

// ==== verilog/systolic_top.sv ====
`default_nettype none

`include "systolic_defs.svh"

module systolic_top import systolic_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        stall_i,
    input  logic        load_weights_i,
    input  logic        compute_i,
    input  weight_vec_t weight_row_i,
    input  act_vec_t    act_vec_i,
    output psum_vec_t   result_vec_o,
    output logic        result_valid_o,
    output logic        weights_ready_o,
    output logic        pipe_empty_o
);

    logic      step;
    logic      weight_shift;
    logic      act_accept;
    act_vec_t  act_top;  // skewed activations at the top of each column.
    psum_vec_t row_sum;  // sums leaving the right edge, still staggered.

    array_ctrl i_array_ctrl (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .stall_i         (stall_i),
        .load_weights_i  (load_weights_i),
        .compute_i       (compute_i),
        .step_o          (step),
        .weight_shift_o  (weight_shift),
        .act_accept_o    (act_accept),
        .result_valid_o  (result_valid_o),
        .weights_ready_o (weights_ready_o),
        .pipe_empty_o    (pipe_empty_o)
    );

    act_skew i_act_skew (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .step_i       (step),
        .act_accept_i (act_accept),
        .act_vec_i    (act_vec_i),
        .act_top_o    (act_top)
    );

    // weight_row_i goes to row 0 on every accepted load.
    mac_array i_mac_array (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .step_i         (step),
        .weight_shift_i (weight_shift),
        .weight_row_i   (weight_row_i),
        .act_top_i      (act_top),
        .row_sum_o      (row_sum)
    );

    result_deskew i_result_deskew (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .step_i       (step),
        .row_sum_i    (row_sum),
        .result_vec_o (result_vec_o)
    );

    // every register in the four blocks advances on the same step, so a stall
    // freezes the whole pipeline in place and the outputs hold.

    // After ARRAY_DIM loads row i holds load number ARRAY_DIM - 1 - i, and an
    // accepted vector x gives result element i as the sum of w[i][j] * x[j].

endmodule

`default_nettype wire
